/* src/hub75_pkg.sv */
package hub75_pkg;

    // Colour channels per pixel
    // Red in the lowest field, then green, then blue
    localparam int CHANNELS = 3;

    // Dark cycles ahead of each latch
    localparam int BLANK_TICKS = 3; // Covers the pixel pipeline drain

    // Scan sequence for one bit-plane
    typedef enum logic [1:0] {
        SHIFT = 2'd0, // Clock one row of both halves in
        BLANK = 2'd1,
        LATCH = 2'd2,
        SHOW  = 2'd3  // Binary weighted on-time
    } scan_state_t;

endpackage

/* src/display_timer.sv */
`timescale 1ns/10ps

module display_timer #(
    parameter int TICKS_W = 5
) (
    input  logic               clk_root,
    input  logic               rst,
    input  logic               load_en,
    input  logic [TICKS_W-1:0] load_ticks,
    output logic               done,
    output logic               busy
);

    logic [TICKS_W-1:0] count; // Cycles left, zero when idle

    always_ff @(posedge clk_root) begin
        if (rst) begin
            count <= '0;
        end else if (load_en) begin
            count <= load_ticks;
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

    // Last cycle of the interval, N cycles after the load
    assign done = (count == TICKS_W'(1));

    // The scan reloads only once the previous interval has run out
    a_no_reload: assert property (@(posedge clk_root) disable iff (rst)
        load_en |-> !busy);

endmodule

/* src/framebuffer.sv */
`timescale 1ns/10ps

module framebuffer #(
    parameter int COLS = 8,
    parameter int ROWS = 8,
    parameter int BITS = 3,
    localparam int AW = $clog2(ROWS * COLS),
    localparam int BA_W = $clog2(ROWS / 2 * COLS),
    localparam int PW = hub75_pkg::CHANNELS * BITS
) (
    input  logic            clk_root,
    input  logic            rst,
    input  logic            wr_valid,
    output logic            wr_ready,
    input  logic [AW-1:0]   wr_addr,
    input  logic [PW-1:0]   wr_pixel,
    input  logic            fetch_en,
    input  logic [BA_W-1:0] rd_addr,
    output logic [PW-1:0]   rd_top,
    output logic [PW-1:0]   rd_bottom
);

    localparam int DEPTH = ROWS / 2 * COLS; // Words per bank

    logic [PW-1:0]   bank_top [DEPTH];
    logic [PW-1:0]   bank_bottom [DEPTH];
    logic            ready_q;
    logic            wr_fire;
    logic            wr_half;   // High for the bottom half
    logic [BA_W-1:0] port_addr;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
        end
    end

    assign wr_ready = ready_q & ~fetch_en; // Scan fetch wins the port
    assign wr_fire  = wr_valid & wr_ready;
    assign wr_half  = wr_addr[AW-1];

    // One shared address for both banks
    assign port_addr = fetch_en ? rd_addr : wr_addr[BA_W-1:0];

    always_ff @(posedge clk_root) begin
        if (wr_fire && !wr_half) begin
            bank_top[port_addr] <= wr_pixel;
        end
        if (wr_fire && wr_half) begin
            bank_bottom[port_addr] <= wr_pixel;
        end
        if (fetch_en) begin
            rd_top    <= bank_top[port_addr]; // Held until the next fetch
            rd_bottom <= bank_bottom[port_addr];
        end
    end

    // A write stalled by a fetch takes the port in the very next cycle
    a_fetch_then_write: assert property (@(posedge clk_root) disable iff (rst)
        (wr_valid && fetch_en) |-> !wr_fire ##1 wr_fire);

endmodule

/* src/pixel_slicer.sv */
`timescale 1ns/10ps

module pixel_slicer #(
    parameter int BITS = 3,
    localparam int PL_W = (BITS > 1) ? $clog2(BITS) : 1,
    localparam int PW = hub75_pkg::CHANNELS * BITS
) (
    input  logic                           clk_root,
    input  logic                           rst,
    input  logic                           fetch_en,
    input  logic [PL_W-1:0]                plane,
    input  logic [hub75_pkg::CHANNELS-1:0] color_enable,
    input  logic [BITS-1:0]                plane_enable,
    input  logic [PW-1:0]                  rd_top,
    input  logic [PW-1:0]                  rd_bottom,
    output logic [hub75_pkg::CHANNELS-1:0] rgb_top,
    output logic [hub75_pkg::CHANNELS-1:0] rgb_bottom,
    output logic                           clk_pixel
);

    logic data_q;   // Fetched words present on rd_top and rd_bottom
    logic shown_q;  // Sliced bits on the panel lines
    logic plane_on;

    assign plane_on = plane_enable[plane];

    always_ff @(posedge clk_root) begin
        if (rst) begin
            data_q    <= 1'b0;
            shown_q   <= 1'b0;
            clk_pixel <= 1'b0;
        end else begin
            data_q    <= fetch_en;
            shown_q   <= data_q;
            clk_pixel <= shown_q; // Rises one cycle after the data settles
        end
    end

    // Pick bit plane of each channel field, masked
    always_ff @(posedge clk_root) begin
        if (data_q) begin
            for (int c = 0; c < hub75_pkg::CHANNELS; c++) begin
                rgb_top[c]    <= rd_top[c * BITS + int'(plane)]
                                 & color_enable[c] & plane_on;
                rgb_bottom[c] <= rd_bottom[c * BITS + int'(plane)]
                                 & color_enable[c] & plane_on;
            end
        end
    end

endmodule

/* src/scan_fsm.sv */
`timescale 1ns/10ps

module scan_fsm #(
    parameter int COLS = 8,
    parameter int ROWS = 8,
    parameter int BITS = 3,
    parameter int BASE_TICKS = 4,
    localparam int PAIRS = ROWS / 2,
    localparam int BA_W = $clog2(PAIRS * COLS),
    localparam int PL_W = (BITS > 1) ? $clog2(BITS) : 1,
    localparam int ROW_W = (PAIRS > 1) ? $clog2(PAIRS) : 1,
    localparam int MAX_TICKS = BASE_TICKS << (BITS - 1),
    localparam int TICKS_W = $clog2(((MAX_TICKS > hub75_pkg::BLANK_TICKS) ?
                                     MAX_TICKS : hub75_pkg::BLANK_TICKS) + 1)
) (
    input  logic               clk_root,
    input  logic               rst,
    output logic               fetch_en,
    output logic [BA_W-1:0]    rd_addr,
    output logic [PL_W-1:0]    plane,
    output logic [ROW_W-1:0]   row_addr,
    output logic               row_latch,
    output logic               output_enable,
    output logic               load_en,
    output logic [TICKS_W-1:0] load_ticks,
    input  logic               done
);

    localparam int COL_W = $clog2(COLS + 1); // Counts one past the last column

    hub75_pkg::scan_state_t state;
    logic [COL_W-1:0] col;
    logic             phase;      // Second cycle of a column
    logic [ROW_W-1:0] pair;
    logic             shift_end;
    logic             plane_last;
    logic             pair_last;

    assign shift_end  = (state == hub75_pkg::SHIFT) && phase && (col == COL_W'(COLS));
    assign plane_last = (plane == PL_W'(BITS - 1));
    assign pair_last  = (pair == ROW_W'(PAIRS - 1));

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state    <= hub75_pkg::SHIFT;
            col      <= '0;
            phase    <= 1'b1; // Idle half column before the first fetch
            plane    <= '0;
            pair     <= '0;
            row_addr <= '0;
        end else begin
            case (state)
                hub75_pkg::SHIFT: begin
                    phase <= ~phase;
                    if (!phase) begin
                        col <= col + 1'b1; // Advance as the fetch goes out
                    end
                    if (shift_end) begin
                        state <= hub75_pkg::BLANK;
                    end
                end
                hub75_pkg::BLANK: begin
                    if (done) begin
                        state    <= hub75_pkg::LATCH;
                        row_addr <= pair; // Row lines switch while dark
                    end
                end
                hub75_pkg::LATCH: begin
                    state <= hub75_pkg::SHOW;
                end
                default: begin
                    if (done) begin
                        state <= hub75_pkg::SHIFT;
                        col   <= '0;
                        phase <= 1'b0;
                        plane <= plane_last ? '0 : plane + 1'b1;
                        // All planes of this pair shown
                        if (plane_last) begin
                            pair <= pair_last ? '0 : pair + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    assign fetch_en      = (state == hub75_pkg::SHIFT) && !phase;
    assign rd_addr       = BA_W'(pair * COLS + col);
    assign row_latch     = (state == hub75_pkg::LATCH);
    assign output_enable = (state == hub75_pkg::SHOW);

    // Timer loads one cycle ahead so the interval starts on state entry
    assign load_en    = shift_end || (state == hub75_pkg::LATCH);
    assign load_ticks = (state == hub75_pkg::LATCH) ? (TICKS_W'(BASE_TICKS) << plane)
                                                    : TICKS_W'(hub75_pkg::BLANK_TICKS);

    // Latch happens dark and is followed straight away by the show
    a_latch_dark: assert property (@(posedge clk_root) disable iff (rst)
        row_latch |-> !output_enable ##1 output_enable);

    // Fetches only while shifting, and never two in a row
    a_fetch_shift: assert property (@(posedge clk_root) disable iff (rst)
        fetch_en |-> (state == hub75_pkg::SHIFT) ##1 !fetch_en);

endmodule

/* src/hub75_top.sv */
`timescale 1ns/10ps

module hub75_top #(
    parameter int COLS = 8,
    parameter int ROWS = 8,
    parameter int BITS = 3,
    parameter int BASE_TICKS = 4,
    localparam int AW = $clog2(ROWS * COLS),
    localparam int PW = hub75_pkg::CHANNELS * BITS,
    localparam int ROW_W = (ROWS / 2 > 1) ? $clog2(ROWS / 2) : 1
) (
    input  logic                           clk_root,
    input  logic                           rst,
    input  logic                           wr_valid,
    output logic                           wr_ready,
    input  logic [AW-1:0]                  wr_addr,
    input  logic [PW-1:0]                  wr_pixel,
    input  logic [hub75_pkg::CHANNELS-1:0] color_enable,
    input  logic [BITS-1:0]                plane_enable,
    output logic [hub75_pkg::CHANNELS-1:0] rgb_top,
    output logic [hub75_pkg::CHANNELS-1:0] rgb_bottom,
    output logic                           clk_pixel,
    output logic                           row_latch,
    output logic                           output_enable,
    output logic [ROW_W-1:0]               row_addr
);

    localparam int BA_W = $clog2(ROWS / 2 * COLS);
    localparam int PL_W = (BITS > 1) ? $clog2(BITS) : 1;
    localparam int MAX_TICKS = BASE_TICKS << (BITS - 1); // Show time of the top plane
    localparam int TICKS_W = $clog2(((MAX_TICKS > hub75_pkg::BLANK_TICKS) ?
                                     MAX_TICKS : hub75_pkg::BLANK_TICKS) + 1);

    logic               fetch_en;
    logic [BA_W-1:0]    rd_addr;
    logic [PW-1:0]      rd_top;
    logic [PW-1:0]      rd_bottom;
    logic [PL_W-1:0]    plane;
    logic               load_en;
    logic [TICKS_W-1:0] load_ticks;
    logic               done;

    scan_fsm #(
        .COLS       (COLS),
        .ROWS       (ROWS),
        .BITS       (BITS),
        .BASE_TICKS (BASE_TICKS)
    ) scan_i (
        .clk_root      (clk_root),
        .rst           (rst),
        .fetch_en      (fetch_en),
        .rd_addr       (rd_addr),
        .plane         (plane),
        .row_addr      (row_addr),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .load_en       (load_en),
        .load_ticks    (load_ticks),
        .done          (done)
    );

    display_timer #(
        .TICKS_W (TICKS_W)
    ) timer_i (
        .clk_root   (clk_root),
        .rst        (rst),
        .load_en    (load_en),
        .load_ticks (load_ticks),
        .done       (done),
        .busy       ()          // Checked inside the timer only
    );

    framebuffer #(
        .COLS (COLS),
        .ROWS (ROWS),
        .BITS (BITS)
    ) fb_i (
        .clk_root  (clk_root),
        .rst       (rst),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_addr   (wr_addr),
        .wr_pixel  (wr_pixel),
        .fetch_en  (fetch_en),
        .rd_addr   (rd_addr),
        .rd_top    (rd_top),
        .rd_bottom (rd_bottom)
    );

    // Same fetch strobe marks the load into the slicer
    pixel_slicer #(
        .BITS (BITS)
    ) slicer_i (
        .clk_root     (clk_root),
        .rst          (rst),
        .fetch_en     (fetch_en),
        .plane        (plane),
        .color_enable (color_enable),
        .plane_enable (plane_enable),
        .rd_top       (rd_top),
        .rd_bottom    (rd_bottom),
        .rgb_top      (rgb_top),
        .rgb_bottom   (rgb_bottom),
        .clk_pixel    (clk_pixel)
    );

endmodule

/* bench/hub75_tb.sv */
`timescale 1ns/10ps

module hub75_tb;

    localparam int COLS = 8;
    localparam int ROWS = 8;
    localparam int BITS = 3;
    localparam int BASE_TICKS = 4;
    localparam int PAIRS = ROWS / 2;
    localparam int CH = hub75_pkg::CHANNELS;
    localparam int AW = $clog2(ROWS * COLS);
    localparam int PW = CH * BITS;
    localparam int ROW_W = (PAIRS > 1) ? $clog2(PAIRS) : 1;
    localparam int FRAME_LATCHES = PAIRS * BITS;
    // Shift, blank, latch per plane plus the weighted show times
    localparam int FRAME_CYCLES = PAIRS * (BITS * (2 * COLS + hub75_pkg::BLANK_TICKS + 1)
                                           + BASE_TICKS * ((1 << BITS) - 1));
    localparam int CYCLE_LIMIT = (5 + 2) * FRAME_CYCLES;

    logic             clk_root = 1'b0;
    logic             rst;
    logic             wr_valid;
    logic             wr_ready;
    logic [AW-1:0]    wr_addr;
    logic [PW-1:0]    wr_pixel;
    logic [CH-1:0]    color_enable;
    logic [BITS-1:0]  plane_enable;
    logic [CH-1:0]    rgb_top;
    logic [CH-1:0]    rgb_bottom;
    logic             clk_pixel;
    logic             row_latch;
    logic             output_enable;
    logic [ROW_W-1:0] row_addr;

    logic [PW-1:0] model [ROWS * COLS]; // Expected framebuffer contents
    logic [CH-1:0] got_top [COLS];
    logic [CH-1:0] got_bottom [COLS];
    int            errors = 0;
    int            cycle = 0;
    int            col_idx = 0;
    int            latch_count = 0;
    int            show_plane = 0;
    int            oe_run = 0;
    int            lt_plane;
    int            lt_pair;
    logic          check_en;

    hub75_top dut_i (
        .clk_root      (clk_root),
        .rst           (rst),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .wr_addr       (wr_addr),
        .wr_pixel      (wr_pixel),
        .color_enable  (color_enable),
        .plane_enable  (plane_enable),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .row_addr      (row_addr)
    );

    always #2 clk_root = ~clk_root;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: expected %h, got %h at cycle %0d",
                     name, expected, actual, cycle);
        end
    endtask

    // Panel bit of one pixel for a plane, after both masks
    function automatic logic [CH-1:0] plane_bits(input logic [PW-1:0] pix, input int pl);
        logic [CH-1:0] bits;
        for (int c = 0; c < CH; c++) begin
            bits[c] = pix[c * BITS + pl] & color_enable[c] & plane_enable[pl];
        end
        return bits;
    endfunction

    // Holds the request until the port takes it
    task automatic write_pixel(input int addr, input logic [PW-1:0] pix);
        logic accepted;
        accepted = 1'b0;
        wr_valid = 1'b1;
        wr_addr  = AW'(addr);
        wr_pixel = pix;
        while (!accepted) begin
            @(negedge clk_root);
            accepted = wr_ready;
            @(posedge clk_root);
            #1;
        end
        model[addr] = pix;
        wr_valid = 1'b0;
    endtask

    task automatic write_burst(input int count, input bit sweep);
        int gap;
        for (int i = 0; i < count; i++) begin
            if (sweep) begin
                write_pixel(i, PW'($urandom));
            end else begin
                write_pixel(int'($urandom_range(0, ROWS * COLS - 1)), PW'($urandom));
            end
            gap = int'($urandom_range(0, 2)); // Random idle cycles on wr_valid
            repeat (gap) begin
                @(posedge clk_root);
                #1;
            end
        end
    endtask

    task automatic wait_latches(input int n);
        int target;
        target = latch_count + n;
        while (latch_count < target) begin
            @(posedge clk_root);
        end
        #1;
    endtask

    always @(posedge clk_root) begin
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles, %0d errors",
                     CYCLE_LIMIT, errors);
            $display("Checks failed");
            $finish;
        end
    end

    // Panel monitor, sampled mid cycle
    always @(negedge clk_root) begin
        if (cycle > 0 && rst) begin
            compare_value("wr_ready", 32'(0), 32'(wr_ready));
        end else if (cycle > 0) begin
            if (clk_pixel) begin
                if (col_idx < COLS) begin
                    got_top[col_idx]    = rgb_top;
                    got_bottom[col_idx] = rgb_bottom;
                end
                col_idx++;
            end
            if (output_enable) begin
                oe_run++;
            end else if (oe_run != 0) begin
                compare_value("output_enable run", 32'(BASE_TICKS << show_plane), 32'(oe_run));
                oe_run = 0;
            end
            if (row_latch) begin
                lt_plane = latch_count % BITS;
                lt_pair  = (latch_count / BITS) % PAIRS;
                compare_value("row_addr", 32'(lt_pair), 32'(row_addr));
                compare_value("clk_pixel pulses", 32'(COLS), 32'(col_idx));
                if (output_enable) begin
                    errors++;
                    $display("row_latch and output_enable were high together at cycle %0d",
                             cycle);
                end
                if (check_en) begin
                    for (int x = 0; x < COLS; x++) begin
                        compare_value($sformatf("rgb_top col %0d", x),
                                      32'(plane_bits(model[lt_pair * COLS + x], lt_plane)),
                                      32'(got_top[x]));
                        compare_value($sformatf("rgb_bottom col %0d", x),
                                      32'(plane_bits(model[(lt_pair + PAIRS) * COLS + x],
                                                     lt_plane)),
                                      32'(got_bottom[x]));
                    end
                end
                show_plane = lt_plane;
                latch_count++;
                col_idx = 0;
            end
        end
    end

    initial begin
        void'($urandom(32'h532ceb7e));
        rst          = 1'b1;
        wr_valid     = 1'b0;
        wr_addr      = '0;
        wr_pixel     = '0;
        color_enable = '1;
        plane_enable = '1;
        check_en     = 1'b0;
        repeat (3) @(posedge clk_root);
        #1;
        rst = 1'b0;

        // Every pixel once, then random addresses on top
        write_burst(ROWS * COLS, 1'b1);
        write_burst(16, 1'b0);
        wait_latches(FRAME_LATCHES); // Rows shifted during the writes
        check_en = 1'b1;
        wait_latches(FRAME_LATCHES);

        color_enable = CH'($urandom);
        plane_enable = BITS'($urandom);
        wait_latches(FRAME_LATCHES);

        check_en     = 1'b0;
        color_enable = '1;
        plane_enable = '1;
        write_burst(16, 1'b0);
        wait_latches(FRAME_LATCHES);
        check_en = 1'b1;
        wait_latches(FRAME_LATCHES);

        $display("Run finished after %0d cycles and %0d latches with %0d errors",
                 cycle, latch_count, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* list.f */
src/hub75_pkg.sv
src/display_timer.sv
src/framebuffer.sv
src/pixel_slicer.sv
src/scan_fsm.sv
src/hub75_top.sv
bench/hub75_tb.sv

/* run.sh */
#!/bin/bash
# Build and run the HUB75 testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module hub75_tb -f list.f -o hub75_sim
./obj_dir/hub75_sim | tee sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0
